//--- common/decode_pkg.sv
// ------------------------------------------------
// Decode stage package
// Widths, operation encodings and the packed structs
// passed between fetch, decode and execute
// ------------------------------------------------

package decode_pkg;

	localparam int W_ADDR = 32;

	typedef logic [W_ADDR-1:0] word_t;
	typedef logic [4:0]        reg_addr_t;

	// Major opcode, instruction bits 6:2
	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011
	} opcode_t;

	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_LT, ALUOP_LTU,
		ALUOP_XOR, ALUOP_OR, ALUOP_AND, ALUOP_SLL,
		ALUOP_SRL, ALUOP_SRA, ALUOP_RS2, ALUOP_MULDIV
	} alu_op_t;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_t;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_t;

	typedef enum logic [3:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU,
		MEMOP_LHU, MEMOP_SB, MEMOP_SH, MEMOP_SW
	} mem_op_t;

	// Ordered to match funct3 of the M opcodes
	typedef enum logic [2:0] {
		M_OP_MUL, M_OP_MULH, M_OP_MULHSU, M_OP_MULHU,
		M_OP_DIV, M_OP_DIVU, M_OP_REM, M_OP_REMU
	} mul_op_t;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ALWAYS, BCOND_ZERO, BCOND_NZERO} bcond_t;

	typedef enum logic [1:0] {EXCEPT_NONE, EXCEPT_INSTR_FAULT, EXCEPT_INSTR_ILLEGAL} except_t;

	// Fetch window, vld is thermometer coded per halfword
	typedef struct packed {
		word_t      cir;
		logic [1:0] err;
		logic [1:0] vld;
	} cir_window_t;

	typedef struct packed {
		logic  jump_now;
		word_t target;
		logic  not_except;
	} jump_req_t;

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;
		alusrc_a_t alusrc_a;
		alusrc_b_t alusrc_b;
		alu_op_t   aluop;
		mem_op_t   memop;
		mul_op_t   mulop;
		bcond_t    branchcond;
		word_t     addr_offs;
		logic      addr_is_regoffs;
		except_t   except;
	} decode_ctrl_t;

endpackage

//--- hw/pc_ctrl.sv
// ------------------------------------------------
// Decode PC control
// Tracks the PC of the instruction in decode, works
// out stall and starvation, the halfword consume
// count and the instruction register lock
// ------------------------------------------------

`timescale 1ns/1ps

module pc_ctrl #(
	parameter decode_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cir_vld_full_i,
	input  logic                  x_stall_i,
	input  decode_pkg::jump_req_t jump_i,
	output logic                  starved_o,
	output logic [1:0]            cir_use_o,
	output logic                  cir_lock_o,
	output logic                  lock_prev_o,
	output decode_pkg::word_t     pc_o
);

	import decode_pkg::*;

	logic  starved;
	logic  stall;
	logic  assert_lock;
	logic  lock_q;
	word_t pc_q;

	// Every instruction is 32 bits, so both halfwords must be present
	assign starved     = !cir_vld_full_i;
	assign stall       = starved || x_stall_i;
	assign cir_use_o   = stall ? 2'd0 : 2'd2;
	assign starved_o   = starved;

	// A jump taken while decode is stalled must keep the instruction in the
	// CIR, or fetch could overwrite it before its link or recovery completes
	assign assert_lock = jump_i.jump_now && jump_i.not_except && stall;
	assign cir_lock_o  = assert_lock || (lock_q && stall);
	assign lock_prev_o = lock_q;
	assign pc_o        = pc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_q <= 1'b0;
		end else begin
			lock_q <= cir_lock_o;
		end
	end

	// The target is still on the jump input when the lock releases
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_VECTOR;
		end else if ((jump_i.jump_now && !assert_lock) || (lock_q && !stall)) begin
			pc_q <= jump_i.target;
		end else if (!stall && !cir_lock_o) begin
			pc_q <= pc_q + W_ADDR'(4);
		end
	end

endmodule

//--- hw/decode/imm_gen.sv
// ------------------------------------------------
// Immediate generator
// Builds the I, S, B, U and J immediates and picks
// the address offset for the current opcode
// ------------------------------------------------

`timescale 1ns/1ps

module imm_gen (
	input  decode_pkg::word_t instr_i,
	output decode_pkg::word_t imm_i_o,
	output decode_pkg::word_t imm_u_o,
	output decode_pkg::word_t addr_offs_o
);

	import decode_pkg::*;

	opcode_t opcode;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_j;

	assign opcode  = opcode_t'(instr_i[6:2]);

	// All formats sign extend from bit 31
	assign imm_i_o = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s   = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b   = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u_o = {instr_i[31:12], 12'h000};
	assign imm_j   = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	always_comb begin
		case (opcode)
			OPC_JAL:            addr_offs_o = imm_j;
			OPC_BRANCH:         addr_offs_o = imm_b;
			OPC_STORE:          addr_offs_o = imm_s;
			OPC_JALR, OPC_LOAD: addr_offs_o = imm_i_o;
			default:            addr_offs_o = '0;
		endcase
	end

endmodule

//--- hw/decode/instr_decode.sv
// ------------------------------------------------
// Instruction decoder
// Maps one RV32IM instruction onto the raw control
// word for execute and flags unknown encodings
// ------------------------------------------------

`timescale 1ns/1ps

module instr_decode #(
	parameter bit EXTENSION_M = 1'b1
) (
	input  decode_pkg::word_t        instr_i,
	input  decode_pkg::word_t        imm_i_i,
	input  decode_pkg::word_t        imm_u_i,
	input  decode_pkg::word_t        addr_offs_i,
	output decode_pkg::decode_ctrl_t ctrl_o,
	output logic                     illegal_o
);

	import decode_pkg::*;

	localparam reg_addr_t X0 = '0;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       bad_field;

	assign opcode = opcode_t'(instr_i[6:2]);
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// Compressed encodings are not supported
	assign illegal_o = bad_field || (instr_i[1:0] != 2'b11);

	// Shared by the register and immediate forms, alt picks SUB and SRA
	function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000:  op = alt ? ALUOP_SUB : ALUOP_ADD;
			3'b001:  op = ALUOP_SLL;
			3'b010:  op = ALUOP_LT;
			3'b011:  op = ALUOP_LTU;
			3'b100:  op = ALUOP_XOR;
			3'b101:  op = alt ? ALUOP_SRA : ALUOP_SRL;
			3'b110:  op = ALUOP_OR;
			default: op = ALUOP_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl_o.rs1             = instr_i[19:15];
		ctrl_o.rs2             = instr_i[24:20];
		ctrl_o.rd              = instr_i[11:7];
		ctrl_o.imm             = imm_i_i;
		ctrl_o.alusrc_a        = ALUSRCA_RS1;
		ctrl_o.alusrc_b        = ALUSRCB_RS2;
		ctrl_o.aluop           = ALUOP_ADD;
		ctrl_o.memop           = MEMOP_NONE;
		ctrl_o.mulop           = M_OP_MUL;
		ctrl_o.branchcond      = BCOND_NEVER;
		ctrl_o.addr_offs       = addr_offs_i;
		ctrl_o.addr_is_regoffs = 1'b0;
		ctrl_o.except          = EXCEPT_NONE;
		bad_field              = 1'b0;

		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				ctrl_o.rs1      = X0;
				ctrl_o.rs2      = X0;
				ctrl_o.imm      = imm_u_i;
				ctrl_o.alusrc_b = ALUSRCB_IMM;
				if (opcode == OPC_LUI) begin
					ctrl_o.aluop = ALUOP_RS2;
				end else begin
					ctrl_o.alusrc_a = ALUSRCA_PC;
				end
			end
			OPC_JAL, OPC_JALR: begin
				// Execute computes the link address as PC + 4
				ctrl_o.rs2        = X0;
				ctrl_o.imm        = word_t'(4);
				ctrl_o.alusrc_a   = ALUSRCA_PC;
				ctrl_o.alusrc_b   = ALUSRCB_IMM;
				ctrl_o.branchcond = BCOND_ALWAYS;
				if (opcode == OPC_JAL) begin
					ctrl_o.rs1 = X0;
				end else begin
					ctrl_o.addr_is_regoffs = 1'b1;
					bad_field              = funct3 != 3'b000;
				end
			end
			OPC_BRANCH: begin
				// funct3 bit 0 inverts the sense, bit 2 selects a compare
				ctrl_o.rd         = X0;
				ctrl_o.aluop      = funct3[2] ? (funct3[1] ? ALUOP_LTU : ALUOP_LT) : ALUOP_SUB;
				ctrl_o.branchcond = (funct3[2] ^ funct3[0]) ? BCOND_NZERO : BCOND_ZERO;
				bad_field         = funct3[2:1] == 2'b01;
			end
			OPC_LOAD: begin
				ctrl_o.rs2             = X0;
				ctrl_o.addr_is_regoffs = 1'b1;
				case (funct3)
					3'b000:  ctrl_o.memop = MEMOP_LB;
					3'b001:  ctrl_o.memop = MEMOP_LH;
					3'b010:  ctrl_o.memop = MEMOP_LW;
					3'b100:  ctrl_o.memop = MEMOP_LBU;
					3'b101:  ctrl_o.memop = MEMOP_LHU;
					default: bad_field = 1'b1;
				endcase
			end
			OPC_STORE: begin
				ctrl_o.rd              = X0;
				ctrl_o.aluop           = ALUOP_RS2;
				ctrl_o.addr_is_regoffs = 1'b1;
				case (funct3)
					3'b000:  ctrl_o.memop = MEMOP_SB;
					3'b001:  ctrl_o.memop = MEMOP_SH;
					3'b010:  ctrl_o.memop = MEMOP_SW;
					default: bad_field = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				ctrl_o.rs2      = X0;
				ctrl_o.alusrc_b = ALUSRCB_IMM;
				ctrl_o.aluop    = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001) begin
					bad_field = funct7 != 7'b0000000;
				end else if (funct3 == 3'b101) begin
					bad_field = (funct7 & 7'b1011111) != 7'b0000000;
				end
			end
			OPC_OP: begin
				if (funct7 == 7'b0000001) begin
					ctrl_o.aluop = ALUOP_MULDIV;
					ctrl_o.mulop = mul_op_t'(funct3);
					bad_field    = !EXTENSION_M;
				end else begin
					ctrl_o.aluop = alu_from_funct3(funct3, funct7[5]);
					bad_field    = !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 &&
						(funct3 == 3'b000 || funct3 == 3'b101)));
				end
			end
			OPC_MISC_MEM: begin
				// FENCE is a no-op on this core
				ctrl_o.rd = X0;
				bad_field = funct3 != 3'b000;
			end
			default: begin
				bad_field = 1'b1;
			end
		endcase
	end

endmodule

//--- hw/decode/decode_squash.sv
// ------------------------------------------------
// Decode squash
// Detects instruction bus faults and turns a faulty,
// illegal or starved decode into a harmless word
// ------------------------------------------------

`timescale 1ns/1ps

module decode_squash (
	input  decode_pkg::decode_ctrl_t ctrl_i,
	input  logic                     illegal_i,
	input  logic                     starved_i,
	input  logic                     lock_prev_i,
	input  logic [1:0]               cir_err_i,
	input  logic [1:0]               cir_vld_i,
	output decode_pkg::decode_ctrl_t ctrl_o
);

	import decode_pkg::*;

	logic bus_fault;

	// Errors on halfwords that have not arrived yet are ignored
	assign bus_fault = (cir_vld_i[0] && cir_err_i[0]) || (cir_vld_i[1] && cir_err_i[1]);

	always_comb begin
		ctrl_o = ctrl_i;
		if (bus_fault || illegal_i || starved_i) begin
			ctrl_o.rs1        = '0;
			ctrl_o.rs2        = '0;
			ctrl_o.rd         = '0;
			ctrl_o.memop      = MEMOP_NONE;
			ctrl_o.branchcond = BCOND_NEVER;
			ctrl_o.aluop      = ALUOP_ADD;
			if (bus_fault) begin
				ctrl_o.except = EXCEPT_INSTR_FAULT;
			end else if (illegal_i && !starved_i) begin
				ctrl_o.except = EXCEPT_INSTR_ILLEGAL;
			end else begin
				ctrl_o.except = EXCEPT_NONE;
			end
		end
		// A locked instruction has already issued its jump
		if (lock_prev_i) begin
			ctrl_o.branchcond = BCOND_NEVER;
		end
	end

endmodule

//--- hw/decode_stage.sv
// ------------------------------------------------
// RV32 decode stage
// Consumes the fetch window, tracks the PC and
// produces the control word for execute
// ------------------------------------------------

`timescale 1ns/1ps

module decode_stage #(
	parameter decode_pkg::word_t RESET_VECTOR = 32'h0000_0000,
	parameter bit                EXTENSION_M  = 1'b1
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  decode_pkg::cir_window_t  cir_i,
	input  decode_pkg::jump_req_t    jump_i,
	input  logic                     x_stall_i,
	output logic [1:0]               cir_use_o,
	output logic                     cir_lock_o,
	output decode_pkg::word_t        pc_o,
	output decode_pkg::decode_ctrl_t ctrl_o
);

	import decode_pkg::*;

	logic         starved;
	logic         lock_prev;
	logic         illegal;
	word_t        imm_i;
	word_t        imm_u;
	word_t        addr_offs;
	decode_ctrl_t raw_ctrl;

	// --------------------------------------------------
	// PC and CIR control

	pc_ctrl #(
		.RESET_VECTOR (RESET_VECTOR)
	) pc_ctrl_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.cir_vld_full_i (cir_i.vld[1]),
		.x_stall_i      (x_stall_i),
		.jump_i         (jump_i),
		.starved_o      (starved),
		.cir_use_o      (cir_use_o),
		.cir_lock_o     (cir_lock_o),
		.lock_prev_o    (lock_prev),
		.pc_o           (pc_o)
	);

	// --------------------------------------------------
	// Instruction decode

	imm_gen imm_gen_i (
		.instr_i     (cir_i.cir),
		.imm_i_o     (imm_i),
		.imm_u_o     (imm_u),
		.addr_offs_o (addr_offs)
	);

	instr_decode #(
		.EXTENSION_M (EXTENSION_M)
	) instr_decode_i (
		.instr_i     (cir_i.cir),
		.imm_i_i     (imm_i),
		.imm_u_i     (imm_u),
		.addr_offs_i (addr_offs),
		.ctrl_o      (raw_ctrl),
		.illegal_o   (illegal)
	);

	decode_squash decode_squash_i (
		.ctrl_i      (raw_ctrl),
		.illegal_i   (illegal),
		.starved_i   (starved),
		.lock_prev_i (lock_prev),
		.cir_err_i   (cir_i.err),
		.cir_vld_i   (cir_i.vld),
		.ctrl_o      (ctrl_o)
	);

endmodule

//--- tests/tb_decode_stage.sv
// ------------------------------------------------
// Decode stage testbench
// Replays the case file one line per cycle, checks
// the control word, the consume count and the lock,
// and follows the PC with its own model
// ------------------------------------------------

`timescale 1ns/1ps

module tb_decode_stage;

	import decode_pkg::*;

	localparam word_t RESET_VECTOR = 32'h0000_0100;
	localparam string CASE_FILE    = "tests/decode_cases.txt";

	typedef struct packed {
		logic [31:0] cir;
		logic [1:0]  err;
		logic [1:0]  vld;
		logic        x_stall;
		logic        jump_now;
		logic [31:0] target;
		logic        not_except;
		logic [1:0]  use_exp;
		logic        lock_exp;
		logic [4:0]  rd_exp;
		logic [4:0]  rs1_exp;
		logic [3:0]  aluop_exp;
		logic [3:0]  memop_exp;
		logic [2:0]  mulop_exp;
		logic [1:0]  src_exp;
		logic [1:0]  bcond_exp;
		logic [31:0] imm_exp;
		logic [31:0] offs_exp;
		logic [1:0]  except_exp;
	} case_t;

	logic         clk;
	logic         rst_n;
	cir_window_t  cir_i;
	jump_req_t    jump_i;
	logic         x_stall;
	logic [1:0]   cir_use_o;
	logic         cir_lock_o;
	word_t        pc_o;
	decode_ctrl_t ctrl_o;

	case_t cases[$];
	int    case_idx;
	int    fail_count;
	int    cycle_count;
	int    cycle_limit;
	word_t pc_model;
	logic  lock_prev_model;

	decode_stage #(
		.RESET_VECTOR (RESET_VECTOR),
		.EXTENSION_M  (1'b1)
	) decode_stage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cir_i      (cir_i),
		.jump_i     (jump_i),
		.x_stall_i  (x_stall),
		.cir_use_o  (cir_use_o),
		.cir_lock_o (cir_lock_o),
		.pc_o       (pc_o),
		.ctrl_o     (ctrl_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// Run limit, counted in clock cycles

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("ERRORS FOUND");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			fail_count = fail_count + 1;
			$display("CHECK FAILED at %0t: case %0d %s is %h, expected %h",
				$time, case_idx, name, got, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		logic [31:0] fld [0:18];
		case_t       c;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("The case file %s could not be opened", CASE_FILE);
			$display("ERRORS FOUND");
			$fatal(1, "Missing case file");
		end
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
				fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
				fld[17], fld[18]);
			// Comment and blank lines hold no fields
			if (n > 0) begin
				if (n != 19) begin
					$display("A line of the case file has %0d fields instead of 19", n);
					$display("ERRORS FOUND");
					$fatal(1, "Malformed case file");
				end
				c.cir        = fld[0];
				c.err        = fld[1][1:0];
				c.vld        = fld[2][1:0];
				c.x_stall    = fld[3][0];
				c.jump_now   = fld[4][0];
				c.target     = fld[5];
				c.not_except = fld[6][0];
				c.use_exp    = fld[7][1:0];
				c.lock_exp   = fld[8][0];
				c.rd_exp     = fld[9][4:0];
				c.rs1_exp    = fld[10][4:0];
				c.aluop_exp  = fld[11][3:0];
				c.memop_exp  = fld[12][3:0];
				c.mulop_exp  = fld[13][2:0];
				c.src_exp    = fld[14][1:0];
				c.bcond_exp  = fld[15][1:0];
				c.imm_exp    = fld[16];
				c.offs_exp   = fld[17];
				c.except_exp = fld[18][1:0];
				cases.push_back(c);
			end
		end
		$fclose(fd);
		if (cases.size() == 0) begin
			$display("The case file %s holds no cases", CASE_FILE);
			$display("ERRORS FOUND");
			$fatal(1, "Empty case file");
		end
	endtask

	task automatic drive_inputs(input case_t c);
		cir_i.cir         = c.cir;
		cir_i.err         = c.err;
		cir_i.vld         = c.vld;
		x_stall           = c.x_stall;
		jump_i.jump_now   = c.jump_now;
		jump_i.target     = c.target;
		jump_i.not_except = c.not_except;
	endtask

	task automatic check_outputs(input case_t c);
		logic       squashed;
		logic [4:0] opcode;
		squashed = (c.except_exp != 2'd0) || !c.vld[1];
		opcode   = c.cir[6:2];
		check_value("cir_use", 32'(cir_use_o), 32'(c.use_exp));
		check_value("cir_lock", 32'(cir_lock_o), 32'(c.lock_exp));
		check_value("rd", 32'(ctrl_o.rd), 32'(c.rd_exp));
		check_value("rs1", 32'(ctrl_o.rs1), 32'(c.rs1_exp));
		// A squashed word carries no register indices
		// Register, branch and store forms read rs2 from bits 24:20
		if (squashed) begin
			check_value("rs2", 32'(ctrl_o.rs2), 32'd0);
		end else if (opcode == OPC_OP || opcode == OPC_BRANCH || opcode == OPC_STORE) begin
			check_value("rs2", 32'(ctrl_o.rs2), 32'(c.cir[24:20]));
		end
		check_value("aluop", 32'(ctrl_o.aluop), 32'(c.aluop_exp));
		check_value("memop", 32'(ctrl_o.memop), 32'(c.memop_exp));
		check_value("mulop", 32'(ctrl_o.mulop), 32'(c.mulop_exp));
		check_value("alusrc", 32'({ctrl_o.alusrc_a, ctrl_o.alusrc_b}), 32'(c.src_exp));
		check_value("branchcond", 32'(ctrl_o.branchcond), 32'(c.bcond_exp));
		check_value("imm", ctrl_o.imm, c.imm_exp);
		check_value("addr_offs", ctrl_o.addr_offs, c.offs_exp);
		check_value("except", 32'(ctrl_o.except), 32'(c.except_exp));
		check_value("pc", pc_o, pc_model);
	endtask

	// Reference PC and lock, advanced with the inputs seen at the coming edge
	task automatic step_pc_model(input case_t c);
		logic stall;
		logic take_lock;
		logic lock_now;
		stall     = !c.vld[1] || c.x_stall;
		take_lock = c.jump_now && c.not_except && stall;
		lock_now  = take_lock || (lock_prev_model && stall);
		if ((c.jump_now && !take_lock) || (lock_prev_model && !stall)) begin
			pc_model = c.target;
		end else if (!stall && !lock_now) begin
			pc_model = pc_model + 32'd4;
		end
		lock_prev_model = lock_now;
	endtask

	initial begin
		rst_n           = 1'b0;
		cir_i           = '0;
		jump_i          = '0;
		x_stall         = 1'b0;
		case_idx        = 0;
		fail_count      = 0;
		cycle_count     = 0;
		cycle_limit     = 0;
		pc_model        = RESET_VECTOR;
		lock_prev_model = 1'b0;

		load_cases();
		cycle_limit = cases.size() + 20;

		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (int i = 0; i < cases.size(); i++) begin
			@(posedge clk);
			#2;
			drive_inputs(cases[i]);
			#20;
			case_idx = i;
			check_outputs(cases[i]);
			step_pc_model(cases[i]);
		end

		if (fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "%0d checks did not match", fail_count);
		end
	end

endmodule

//--- tests/decode_cases.txt
# cir err vld x_stall jump_now target not_except | expected: cir_use cir_lock rd rs1
# aluop memop mulop alusrc(a,b) branchcond imm addr_offs except, all fields in hex
00510093 0 3 0 0 00000000 0 2 0 01 02 0 0 0 1 0 00000005 00000000 0
fff22193 0 3 0 0 00000000 0 2 0 03 04 2 0 0 1 0 ffffffff 00000000 0
40335293 0 3 0 0 00000000 0 2 0 05 06 9 0 0 1 0 00000403 00000000 0
409403b3 0 3 0 0 00000000 0 2 0 07 08 1 0 0 0 0 00000409 00000000 0
00c5f533 0 3 0 0 00000000 0 2 0 0a 0b 6 0 0 0 0 0000000c 00000000 0
123456b7 0 3 0 0 00000000 0 2 0 0d 00 a 0 0 1 0 12345000 00000000 0
fffff717 0 3 0 0 00000000 0 2 0 0e 00 0 0 0 3 0 fffff000 00000000 0
00208463 0 3 0 0 00000000 0 2 0 00 01 1 0 0 0 2 00000002 00000008 0
fe41eee3 0 3 0 0 00000000 0 2 0 00 03 3 0 0 0 3 ffffffe4 fffffffc 0
0062d063 0 3 0 0 00000000 0 2 0 00 05 2 0 0 0 2 00000006 00000000 0
010000ef 0 3 0 1 00000200 1 2 0 01 00 0 0 0 3 1 00000004 00000010 0
00808067 0 3 0 0 00000000 0 2 0 00 01 0 0 0 3 1 00000004 00000008 0
00c12783 0 3 0 0 00000000 0 2 0 0f 02 0 3 0 0 0 0000000c 0000000c 0
fff1c803 0 3 0 0 00000000 0 2 0 10 03 0 4 0 0 0 ffffffff ffffffff 0
00532a23 0 3 0 0 00000000 0 2 0 00 06 a 8 0 0 0 00000005 00000014 0
fe111f23 0 3 0 0 00000000 0 2 0 00 02 a 7 0 0 0 ffffffe1 fffffffe 0
023100b3 0 3 0 0 00000000 0 2 0 01 02 b 0 0 0 0 00000023 00000000 0
0262f233 0 3 0 0 00000000 0 2 0 04 05 b 0 7 0 0 00000026 00000000 0
0ff0000f 0 3 0 0 00000000 0 2 0 00 00 0 0 0 0 0 000000ff 00000000 0
ffffffff 0 3 0 0 00000000 0 2 0 00 00 0 0 0 0 0 ffffffff 00000000 2
200100b3 0 3 0 0 00000000 0 2 0 00 00 0 0 0 0 0 00000200 00000000 2
00510093 2 3 0 0 00000000 0 2 0 00 00 0 0 0 1 0 00000005 00000000 1
ffffffff 1 3 0 0 00000000 0 2 0 00 00 0 0 0 0 0 ffffffff 00000000 1
ffffffff 2 1 0 0 00000000 0 0 0 00 00 0 0 0 0 0 ffffffff 00000000 0
00510093 1 1 0 0 00000000 0 0 0 00 00 0 0 0 1 0 00000005 00000000 1
00000000 0 0 0 0 00000000 0 0 0 00 00 0 0 0 0 0 00000000 00000000 0
00510093 0 3 1 0 00000000 0 0 0 01 02 0 0 0 1 0 00000005 00000000 0
00510093 0 3 1 1 00000400 0 0 0 01 02 0 0 0 1 0 00000005 00000000 0
010000ef 0 3 1 1 00000300 1 0 1 01 00 0 0 0 3 1 00000004 00000010 0
010000ef 0 3 1 0 00000300 0 0 1 01 00 0 0 0 3 0 00000004 00000010 0
010000ef 0 3 0 0 00000300 0 2 0 01 00 0 0 0 3 0 00000004 00000010 0
00510093 0 3 0 0 00000000 0 2 0 01 02 0 0 0 1 0 00000005 00000000 0
fff22193 0 3 0 0 00000000 0 2 0 03 04 2 0 0 1 0 ffffffff 00000000 0

//--- filelist.f
common/decode_pkg.sv
hw/pc_ctrl.sv
hw/decode/imm_gen.sv
hw/decode/instr_decode.sv
hw/decode/decode_squash.sv
hw/decode_stage.sv
tests/tb_decode_stage.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_decode_stage
RTL_TOP    := decode_stage
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
